// File: mmu_sub.f
logic/mmu_pkg.sv
logic/mmu_csr_regs.sv
logic/tlb_array.sv
logic/mmu.sv
logic/mmu_top.sv
test/mmu_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the mmu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mmu_sub.f --top-module mmu_tb -o mmu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/mmu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Done: no errors"; then
    exit 0
fi
exit 1

// File: test/mmu_tb.sv
`timescale 1ns/1ps

module mmu_tb import mmu_pkg::*;;

    localparam int ENTRIES = 16;
    // rough cycle budget per test with reset counted in the first
    localparam int TEST_CYCLES = 130 + 60 + 150 + 90 + 70 + 40;
    localparam int LIMIT = 3 * TEST_CYCLES;

    logic          clk;
    logic          reset_i;
    axil_req_t     axil_i;
    axil_rsp_t     axil_o;
    trans_req_t    req;
    logic          flush;
    trans_result_t dut_res;

    // shadow of the register file and of the written tlb slots
    logic [31:0] regs [8];
    logic [31:0] tlb_hi [ENTRIES];
    logic [31:0] tlb_lo0 [ENTRIES];
    logic [31:0] tlb_lo1 [ENTRIES];
    logic [9:0]  tlb_asid [ENTRIES];

    trans_result_t exp_q [$];
    trans_result_t exp_cur;
    logic          result_ok;
    logic [31:0]   seed;
    int            errors;
    int            checks;
    int            cycles;

    mmu_top #(
        .TLB_ENTRY_NUM(ENTRIES)
    ) u_mmu_top (
        .clk     (clk),
        .reset_i (reset_i),
        .axil_i  (axil_i),
        .axil_o  (axil_o),
        .req_i   (req),
        .flush_i (flush),
        .result_o(dut_res)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        seed = xorshift(seed);
        return seed;
    endfunction

    function automatic mem_kind_e pick_kind(input logic [31:0] r);
        case (r % 3)
            0: return MEM_FETCH;
            1: return MEM_LOAD;
            default: return MEM_STORE;
        endcase
    endfunction

    // implemented bits of each register per the register map
    function automatic logic [31:0] reg_mask(input int idx);
        case (idx)
            0: return 32'h0000_01eb;
            1: return 32'h0000_03ff;
            2, 3: return 32'hee00_0039;
            4: return 32'hffff_e007;
            5, 6: return 32'hffff_f03f;
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic window_hit(input logic [31:0] w, input logic [1:0] plv,
                                        input logic [31:0] va);
        return (w[31:29] == va[31:29]) && ((plv == 2'd0 && w[0]) || (plv == 2'd3 && w[3]));
    endfunction

    // reference translation from the shadow registers
    function automatic trans_result_t model(input logic [31:0] va, input mem_kind_e kind);
        trans_result_t r;
        logic [1:0]    plv;
        logic          hit;
        int            idx;
        logic [31:0]   hi;
        logic [31:0]   lo;
        r = '0;
        r.valid = 1'b1;
        plv = regs[0][1:0];
        hit = 1'b0;
        idx = 0;
        if (regs[0][3]) begin
            r.pa  = va;
            r.mat = (kind == MEM_FETCH) ? regs[0][6:5] : regs[0][8:7];
        end else if (window_hit(regs[2], plv, va)) begin
            r.pa  = {regs[2][27:25], va[28:0]};
            r.mat = regs[2][5:4];
        end else if (window_hit(regs[3], plv, va)) begin
            r.pa  = {regs[3][27:25], va[28:0]};
            r.mat = regs[3][5:4];
        end else begin
            for (int i = 0; i < ENTRIES; i++) begin
                hi = tlb_hi[i];
                if (hi[0] && (hi[1] || tlb_asid[i] == regs[1][9:0]) &&
                    (hi[2] ? va[31:22] == hi[31:22] : va[31:13] == hi[31:13])) begin
                    hit = 1'b1;
                    idx = i;
                end
            end
            hi = tlb_hi[idx];
            lo = (hi[2] ? va[21] : va[12]) ? tlb_lo1[idx] : tlb_lo0[idx];
            r.pa  = hi[2] ? {lo[31:22], va[21:0]} : {lo[31:12], va[11:0]};
            r.mat = lo[5:4];
            if (!hit) begin
                r.ecode = ECODE_TLBR;
            end else if (!lo[0]) begin
                r.ecode = (kind == MEM_FETCH) ? ECODE_PIF :
                          (kind == MEM_LOAD) ? ECODE_PIL : ECODE_PIS;
            end else if (plv > lo[3:2]) begin
                r.ecode = ECODE_PPI;
            end else if (kind == MEM_STORE && !lo[1]) begin
                r.ecode = ECODE_PME;
            end
        end
        r.ok = (r.ecode == ECODE_NONE);
        return r;
    endfunction

    // queue aligned to the two-cycle pipeline
    always @(posedge clk) begin
        trans_result_t e;
        trans_result_t last;
        if (reset_i) begin
            exp_q.delete();
            exp_cur <= '0;
        end else begin
            e = model(req.va, req.kind);
            e.valid = req.valid;
            if (flush) begin
                e.valid = 1'b0;
                if (exp_q.size() > 0) begin
                    last = exp_q[exp_q.size()-1];
                    last.valid = 1'b0;
                    exp_q[exp_q.size()-1] = last;
                end
            end
            exp_q.push_back(e);
            if (exp_q.size() > 1) begin
                last = exp_q.pop_front();
                if (last.valid) begin
                    checks++;
                end
                exp_cur <= last;
            end
        end
    end

    always_comb begin
        result_ok = (dut_res.valid === exp_cur.valid);
        if (exp_cur.valid) begin
            result_ok = result_ok && (dut_res.ok === exp_cur.ok) &&
                        (dut_res.ecode === exp_cur.ecode);
            if (exp_cur.ok) begin
                result_ok = result_ok && (dut_res.pa === exp_cur.pa) &&
                            (dut_res.mat === exp_cur.mat);
            end
        end
    end

    result_check: assert property (@(posedge clk) disable iff (reset_i) result_ok)
        else begin
            errors++;
            $write("mismatch result_o: expected v=%h ok=%h pa=%h mat=%h ecode=%h",
                   $sampled(exp_cur.valid), $sampled(exp_cur.ok), $sampled(exp_cur.pa),
                   $sampled(exp_cur.mat), $sampled(exp_cur.ecode));
            $display(", got v=%h ok=%h pa=%h mat=%h ecode=%h", $sampled(dut_res.valid),
                     $sampled(dut_res.ok), $sampled(dut_res.pa), $sampled(dut_res.mat),
                     $sampled(dut_res.ecode));
        end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic update_shadow(input logic [7:0] addr, input logic [31:0] data,
                                 input logic [3:0] strb);
        logic [31:0] bytes;
        logic [31:0] m;
        int          idx;
        bytes = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        idx = int'(addr[7:2]);
        if (idx < 7) begin
            m = reg_mask(idx) & bytes;
            regs[idx] = (regs[idx] & ~m) | (data & m);
        end else if (idx == 7 && (data & bytes) < ENTRIES) begin
            m = data & bytes;
            tlb_hi[m]   = regs[4];
            tlb_lo0[m]  = regs[5];
            tlb_lo1[m]  = regs[6];
            tlb_asid[m] = regs[1][9:0];
        end
    endtask

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        axil_i.awvalid = 1'b1;
        axil_i.awaddr  = addr;
        axil_i.wvalid  = 1'b1;
        axil_i.wdata   = data;
        axil_i.wstrb   = strb;
        axil_i.bready  = 1'b1;
        @(negedge clk);
        while (!axil_o.awready) @(negedge clk);
        wready_check: assert (axil_o.wready === 1'b1)
            else begin
                errors++;
                $display("mismatch wready: expected 1, got %h", axil_o.wready);
            end
        // accepted at the coming edge
        @(negedge clk);
        axil_i.awvalid = 1'b0;
        axil_i.wvalid  = 1'b0;
        while (!axil_o.bvalid) @(negedge clk);
        bresp_check: assert (axil_o.bresp === 2'b00)
            else begin
                errors++;
                $display("mismatch bresp at %h: expected 0, got %h", addr, axil_o.bresp);
            end
        @(negedge clk);
        axil_i.bready = 1'b0;
        update_shadow(addr, data, strb);
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
        axil_i.arvalid = 1'b1;
        axil_i.araddr  = addr;
        @(negedge clk);
        while (!axil_o.arready) @(negedge clk);
        @(negedge clk);
        axil_i.arvalid = 1'b0;
        while (!axil_o.rvalid) @(negedge clk);
        data = axil_o.rdata;
        rresp_check: assert (axil_o.rresp === 2'b00)
            else begin
                errors++;
                $display("mismatch rresp at %h: expected 0, got %h", addr, axil_o.rresp);
            end
        axil_i.rready = 1'b1;
        @(negedge clk);
        axil_i.rready = 1'b0;
    endtask

    task automatic check_read(input logic [7:0] addr, input logic [31:0] expected);
        logic [31:0] got;
        axil_read(addr, got);
        readback_check: assert (got === expected)
            else begin
                errors++;
                $display("mismatch rdata at %h: expected %h, got %h", addr, expected, got);
            end
    endtask

    task automatic send(input logic [31:0] va, input mem_kind_e kind);
        req.valid = 1'b1;
        req.va    = va;
        req.kind  = kind;
        @(negedge clk);
    endtask

    task automatic drain();
        req.valid = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    task automatic report(input string name, input int errs_before);
        $display("test %s finished with %0d errors", name, errors - errs_before);
    endtask

    initial begin
        int e0;
        logic [31:0] r;
        seed    = 32'h4c675350;
        errors  = 0;
        checks  = 0;
        cycles  = 0;
        reset_i = 1'b1;
        axil_i  = '0;
        req     = '0;
        flush   = 1'b0;
        for (int i = 0; i < 8; i++) regs[i] = '0;
        regs[0] = 32'h0000_0008;
        for (int i = 0; i < ENTRIES; i++) begin
            tlb_hi[i]   = '0;
            tlb_lo0[i]  = '0;
            tlb_lo1[i]  = '0;
            tlb_asid[i] = '0;
        end
        repeat (8) @(negedge clk);
        reset_i = 1'b0;

        // register access with random partial strobes
        e0 = errors;
        for (int i = 0; i < 7; i++) begin
            r = next_rand();
            axil_write(8'(i * 4), next_rand(), r[3:0]);
        end
        for (int i = 0; i < 7; i++) check_read(8'(i * 4), regs[i]);
        check_read(8'h1c, 32'h0);
        check_read(8'h20, 32'h0);
        check_read(8'hfc, 32'h0);
        report("register access", e0);

        // direct mode with datf 1 and datm 2
        e0 = errors;
        axil_write(8'h00, 32'h0000_0128, 4'hf);
        for (int i = 0; i < 32; i++) send(next_rand(), pick_kind(next_rand()));
        drain();
        report("direct mode", e0);

        // segment 5 in both windows with dmw0 enabled for plv0 and then for plv3
        e0 = errors;
        axil_write(8'h0c, 32'ha600_0029, 4'hf);
        for (int k = 0; k < 2; k++) begin
            axil_write(8'h08, (k == 0) ? 32'ha200_0011 : 32'ha200_0018, 4'hf);
            for (int p = 0; p < 4; p++) begin
                axil_write(8'h00, 32'(p), 4'hf);
                for (int i = 0; i < 6; i++) begin
                    r = next_rand();
                    send((i < 4) ? {3'd5, r[28:0]} : r, pick_kind(next_rand()));
                end
                drain();
            end
        end
        report("direct-mapped windows", e0);

        // 4 KB entry in slot 2 and global huge entry in slot 5
        e0 = errors;
        axil_write(8'h00, 32'h0, 4'hf);
        axil_write(8'h08, 32'h0, 4'hf);
        axil_write(8'h0c, 32'h0, 4'hf);
        axil_write(8'h04, 32'h0000_0055, 4'hf);
        axil_write(8'h10, 32'h0a00_0007 | 32'h4040_0000, 4'hf);
        axil_write(8'h14, 32'h0a00_0013, 4'hf);
        axil_write(8'h18, 32'h0c00_0023, 4'hf);
        axil_write(8'h1c, 32'd5, 4'hf);
        axil_write(8'h10, 32'h1234_6001, 4'hf);
        axil_write(8'h14, 32'h8000_101f, 4'hf);
        axil_write(8'h18, 32'h8000_2023, 4'hf);
        axil_write(8'h1c, 32'd2, 4'hf);
        for (int i = 0; i < 8; i++) begin
            send(32'h1234_6000 | (next_rand() & 32'h1fff), pick_kind(next_rand()));
            send(32'h4a40_0000 | (next_rand() & 32'h3f_ffff), pick_kind(next_rand()));
        end
        axil_write(8'h1c, 32'd16, 4'hf);
        drain();
        axil_write(8'h04, 32'h0000_00aa, 4'hf);
        for (int i = 0; i < 4; i++) begin
            send(32'h4a40_0000 | (next_rand() & 32'h3f_ffff), MEM_LOAD);
        end
        drain();
        report("tlb hits", e0);

        // asid mismatch, miss, invalid page, plv and dirty faults
        e0 = errors;
        axil_write(8'h10, 32'h2000_0001, 4'hf);
        axil_write(8'h14, 32'h0012_3032, 4'hf);
        axil_write(8'h18, 32'h0045_6011, 4'hf);
        axil_write(8'h1c, 32'd7, 4'hf);
        send(32'h1234_6abc, MEM_LOAD);
        send(32'hf000_0000 | (next_rand() & 32'h0fff_ffff), MEM_FETCH);
        send(32'h2000_0040, MEM_FETCH);
        send(32'h2000_0080, MEM_LOAD);
        send(32'h2000_00c0, MEM_STORE);
        send(32'h2000_1100, MEM_STORE);
        send(32'h2000_1200, MEM_LOAD);
        drain();
        axil_write(8'h00, 32'h0000_0003, 4'hf);
        send(32'h2000_1300, MEM_LOAD);
        send(32'h2000_1400, MEM_FETCH);
        drain();
        report("tlb exceptions", e0);

        // flush with two requests in flight
        e0 = errors;
        axil_write(8'h00, 32'h0, 4'hf);
        axil_write(8'h04, 32'h0000_0055, 4'hf);
        send(32'h1234_6010, MEM_LOAD);
        send(32'h1234_7020, MEM_STORE);
        flush = 1'b1;
        send(32'h1234_6030, MEM_FETCH);
        flush = 1'b0;
        send(32'h1234_7040, MEM_LOAD);
        drain();
        report("flush", e0);

        $display("%0d translations checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: logic/mmu_top.sv
`timescale 1ns/1ps

module mmu_top import mmu_pkg::*; #(
    parameter int unsigned TLB_ENTRY_NUM = 16
) (
    input  logic          clk,
    input  logic          reset_i,
    input  axil_req_t     axil_i,
    output axil_rsp_t     axil_o,
    input  trans_req_t    req_i,
    input  logic          flush_i,
    output trans_result_t result_o
);

    mmu_cfg_t                 cfg;
    logic [TLB_ENTRY_NUM-1:0] tlb_we;
    tlb_entry_t               tlb_entry;

    mmu_csr_regs #(
        .TLB_ENTRY_NUM(TLB_ENTRY_NUM)
    ) u_csr_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .axil_i     (axil_i),
        .axil_o     (axil_o),
        .cfg_o      (cfg),
        .tlb_we_o   (tlb_we),
        .tlb_entry_o(tlb_entry)
    );

    mmu #(
        .TLB_ENTRY_NUM(TLB_ENTRY_NUM)
    ) u_mmu (
        .clk        (clk),
        .reset_i    (reset_i),
        .flush_i    (flush_i),
        .cfg_i      (cfg),
        .req_i      (req_i),
        .tlb_we_i   (tlb_we),
        .tlb_entry_i(tlb_entry),
        .result_o   (result_o)
    );

endmodule

// File: logic/mmu.sv
`timescale 1ns/1ps

module mmu import mmu_pkg::*; #(
    parameter int unsigned TLB_ENTRY_NUM = 16
) (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     flush_i,
    input  mmu_cfg_t                 cfg_i,
    input  trans_req_t               req_i,
    input  logic [TLB_ENTRY_NUM-1:0] tlb_we_i,
    input  tlb_entry_t               tlb_entry_i,
    output trans_result_t            result_o
);

    trans_req_t    s1_q;
    trans_result_t res_d;
    trans_result_t res_q;
    logic          tlb_hit;
    tlb_key_t      tlb_key;
    tlb_value_t    tlb_value;
    logic          dmw0_hit;
    logic          dmw1_hit;

    function automatic logic dmw_match(dmw_t w, plv_t plv, vaddr_t va);
        return (w.vseg == va[31:29]) &&
               ((plv == 2'd0 && w.plv0) || (plv == 2'd3 && w.plv3));
    endfunction

    // stage one, request register
    always_ff @(posedge clk) begin
        s1_q <= req_i;
        if (reset_i || flush_i) begin
            s1_q.valid <= 1'b0;
        end
    end

    tlb_array #(
        .TLB_ENTRY_NUM(TLB_ENTRY_NUM)
    ) u_tlb_array (
        .clk    (clk),
        .reset_i(reset_i),
        .we_i   (tlb_we_i),
        .entry_i(tlb_entry_i),
        .va_i   (s1_q.va),
        .asid_i (cfg_i.asid),
        .hit_o  (tlb_hit),
        .key_o  (tlb_key),
        .value_o(tlb_value)
    );

    assign dmw0_hit = dmw_match(cfg_i.dmw0, cfg_i.plv, s1_q.va);
    assign dmw1_hit = dmw_match(cfg_i.dmw1, cfg_i.plv, s1_q.va);

    // direct mode, then windows, then tlb
    always_comb begin
        res_d       = '0;
        res_d.valid = s1_q.valid;
        if (cfg_i.da) begin
            res_d.pa  = s1_q.va;
            res_d.mat = (s1_q.kind == MEM_FETCH) ? cfg_i.datf : cfg_i.datm;
        end else if (dmw0_hit) begin
            res_d.pa  = {cfg_i.dmw0.pseg, s1_q.va[28:0]};
            res_d.mat = cfg_i.dmw0.mat;
        end else if (dmw1_hit) begin
            res_d.pa  = {cfg_i.dmw1.pseg, s1_q.va[28:0]};
            res_d.mat = cfg_i.dmw1.mat;
        end else begin
            res_d.mat = tlb_value.mat;
            if (tlb_key.huge_page) begin
                res_d.pa = {tlb_value.ppn[19:10], s1_q.va[21:0]};
            end else begin
                res_d.pa = {tlb_value.ppn, s1_q.va[11:0]};
            end
            // exception priority
            if (!tlb_hit) begin
                res_d.ecode = ECODE_TLBR;
            end else if (!tlb_value.v) begin
                case (s1_q.kind)
                    MEM_FETCH: res_d.ecode = ECODE_PIF;
                    MEM_LOAD:  res_d.ecode = ECODE_PIL;
                    default:   res_d.ecode = ECODE_PIS;
                endcase
            end else if (cfg_i.plv > tlb_value.plv) begin
                res_d.ecode = ECODE_PPI;
            end else if (s1_q.kind == MEM_STORE && !tlb_value.d) begin
                res_d.ecode = ECODE_PME;
            end
        end
        res_d.ok = (res_d.ecode == ECODE_NONE);
    end

    // stage two, result register
    always_ff @(posedge clk) begin
        res_q <= res_d;
        if (reset_i || flush_i) begin
            res_q.valid <= 1'b0;
        end
    end

    assign result_o = res_q;

endmodule

// File: logic/tlb_array.sv
`timescale 1ns/1ps

module tlb_array import mmu_pkg::*; #(
    parameter int unsigned TLB_ENTRY_NUM = 16
) (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic [TLB_ENTRY_NUM-1:0] we_i,
    input  tlb_entry_t               entry_i,
    input  vaddr_t                   va_i,
    input  asid_t                    asid_i,
    output logic                     hit_o,
    output tlb_key_t                 key_o,
    output tlb_value_t               value_o
);

    localparam int unsigned IDX_W = (TLB_ENTRY_NUM > 1) ? $clog2(TLB_ENTRY_NUM) : 1;

    logic [TLB_ENTRY_NUM-1:0] e_q;
    tlb_key_t                 key_q  [TLB_ENTRY_NUM];
    tlb_value_t               even_q [TLB_ENTRY_NUM];
    tlb_value_t               odd_q  [TLB_ENTRY_NUM];
    logic                     hit;
    logic [IDX_W-1:0]         hit_idx;
    logic                     odd_sel;

    function automatic logic vppn_match(tlb_key_t key, vaddr_t va);
        if (key.huge_page) begin
            return va[31:22] == key.vppn[18:9];
        end else begin
            return va[31:13] == key.vppn;
        end
    endfunction

    // entry exist bits
    always_ff @(posedge clk) begin
        if (reset_i) begin
            e_q <= '0;
        end else begin
            for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
                if (we_i[i]) begin
                    e_q[i] <= entry_i.key.e;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
            if (we_i[i]) begin
                key_q[i]  <= entry_i.key;
                even_q[i] <= entry_i.even;
                odd_q[i]  <= entry_i.odd;
            end
        end
    end

    // ascending scan lets the highest matching index win
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
            if (e_q[i] && (key_q[i].g || key_q[i].asid == asid_i) &&
                vppn_match(key_q[i], va_i)) begin
                hit     = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign odd_sel = key_q[hit_idx].huge_page ? va_i[21] : va_i[12];

    always_comb begin
        key_o   = key_q[hit_idx];
        key_o.e = hit;
        value_o = odd_sel ? odd_q[hit_idx] : even_q[hit_idx];
    end

    assign hit_o = hit;

endmodule

// File: logic/mmu_csr_regs.sv
`timescale 1ns/1ps

module mmu_csr_regs import mmu_pkg::*; #(
    parameter int unsigned TLB_ENTRY_NUM = 16
) (
    input  logic                     clk,
    input  logic                     reset_i,
    input  axil_req_t                axil_i,
    output axil_rsp_t                axil_o,
    output mmu_cfg_t                 cfg_o,
    output logic [TLB_ENTRY_NUM-1:0] tlb_we_o,
    output tlb_entry_t               tlb_entry_o
);

    localparam int unsigned IDX_W = (TLB_ENTRY_NUM > 1) ? $clog2(TLB_ENTRY_NUM) : 1;

    // word offsets
    localparam logic [5:0] REG_CRMD    = 6'h0;
    localparam logic [5:0] REG_ASID    = 6'h1;
    localparam logic [5:0] REG_DMW0    = 6'h2;
    localparam logic [5:0] REG_DMW1    = 6'h3;
    localparam logic [5:0] REG_TLBEHI  = 6'h4;
    localparam logic [5:0] REG_TLBELO0 = 6'h5;
    localparam logic [5:0] REG_TLBELO1 = 6'h6;
    localparam logic [5:0] REG_TLBWR   = 6'h7;

    // implemented bits with the rest reading zero
    localparam axil_data_t CRMD_MASK   = 32'h0000_01eb;
    localparam axil_data_t ASID_MASK   = 32'h0000_03ff;
    localparam axil_data_t DMW_MASK    = 32'hee00_0039;
    localparam axil_data_t TLBEHI_MASK = 32'hffff_e007;
    localparam axil_data_t TLBELO_MASK = 32'hffff_f03f;
    localparam axil_data_t CRMD_RESET  = 32'h0000_0008;

    axil_data_t crmd_q, asid_q, dmw0_q, dmw1_q, tlbehi_q, tlbelo0_q, tlbelo1_q;
    logic       aw_ready_q, b_valid_q, ar_ready_q, r_valid_q;
    axil_data_t r_data_q, rd_data, wmask, wr_data;
    logic       wr_fire, rd_fire;
    logic [5:0] wr_idx;
    logic [IDX_W-1:0] wr_slot;
    logic [TLB_ENTRY_NUM-1:0] tlb_we_q;

    function automatic axil_data_t merge(axil_data_t old_v, axil_data_t new_v,
                                         axil_data_t mask);
        return (old_v & ~mask) | (new_v & mask);
    endfunction

    function automatic dmw_t to_dmw(axil_data_t r);
        dmw_t w;
        w.vseg = r[31:29];
        w.pseg = r[27:25];
        w.mat  = r[5:4];
        w.plv3 = r[3];
        w.plv0 = r[0];
        return w;
    endfunction

    function automatic tlb_value_t to_value(axil_data_t r);
        tlb_value_t val;
        val.v   = r[0];
        val.d   = r[1];
        val.plv = r[3:2];
        val.mat = r[5:4];
        val.ppn = r[31:12];
        return val;
    endfunction

    assign wr_fire = aw_ready_q && axil_i.awvalid && axil_i.wvalid;
    assign rd_fire = ar_ready_q && axil_i.arvalid;
    assign wr_idx  = axil_i.awaddr[7:2];
    assign wmask   = {{8{axil_i.wstrb[3]}}, {8{axil_i.wstrb[2]}},
                      {8{axil_i.wstrb[1]}}, {8{axil_i.wstrb[0]}}};
    assign wr_data = axil_i.wdata & wmask;
    assign wr_slot = wr_data[IDX_W-1:0];

    // handshake state
    always_ff @(posedge clk) begin
        if (reset_i) begin
            aw_ready_q <= 1'b0;
            b_valid_q  <= 1'b0;
            ar_ready_q <= 1'b0;
            r_valid_q  <= 1'b0;
        end else begin
            aw_ready_q <= axil_i.awvalid && axil_i.wvalid && !b_valid_q && !aw_ready_q;
            ar_ready_q <= axil_i.arvalid && !r_valid_q && !ar_ready_q;
            if (wr_fire) begin
                b_valid_q <= 1'b1;
            end else if (axil_i.bready) begin
                b_valid_q <= 1'b0;
            end
            if (rd_fire) begin
                r_valid_q <= 1'b1;
            end else if (axil_i.rready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            crmd_q    <= CRMD_RESET;
            asid_q    <= '0;
            dmw0_q    <= '0;
            dmw1_q    <= '0;
            tlbehi_q  <= '0;
            tlbelo0_q <= '0;
            tlbelo1_q <= '0;
            tlb_we_q  <= '0;
        end else begin
            // tlbwr pulse lasts one cycle
            tlb_we_q <= '0;
            if (wr_fire) begin
                case (wr_idx)
                    REG_CRMD:    crmd_q    <= merge(crmd_q, wr_data, CRMD_MASK & wmask);
                    REG_ASID:    asid_q    <= merge(asid_q, wr_data, ASID_MASK & wmask);
                    REG_DMW0:    dmw0_q    <= merge(dmw0_q, wr_data, DMW_MASK & wmask);
                    REG_DMW1:    dmw1_q    <= merge(dmw1_q, wr_data, DMW_MASK & wmask);
                    REG_TLBEHI:  tlbehi_q  <= merge(tlbehi_q, wr_data, TLBEHI_MASK & wmask);
                    REG_TLBELO0: tlbelo0_q <= merge(tlbelo0_q, wr_data, TLBELO_MASK & wmask);
                    REG_TLBELO1: tlbelo1_q <= merge(tlbelo1_q, wr_data, TLBELO_MASK & wmask);
                    REG_TLBWR: begin
                        if (wr_data < TLB_ENTRY_NUM) begin
                            tlb_we_q[wr_slot] <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (axil_i.araddr[7:2])
            REG_CRMD:    rd_data = crmd_q;
            REG_ASID:    rd_data = asid_q;
            REG_DMW0:    rd_data = dmw0_q;
            REG_DMW1:    rd_data = dmw1_q;
            REG_TLBEHI:  rd_data = tlbehi_q;
            REG_TLBELO0: rd_data = tlbelo0_q;
            REG_TLBELO1: rd_data = tlbelo1_q;
            default:     rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            r_data_q <= rd_data;
        end
    end

    always_comb begin
        axil_o.awready = aw_ready_q;
        axil_o.wready  = aw_ready_q;
        axil_o.bvalid  = b_valid_q;
        axil_o.bresp   = AXI_RESP_OKAY;
        axil_o.arready = ar_ready_q;
        axil_o.rvalid  = r_valid_q;
        axil_o.rdata   = r_data_q;
        axil_o.rresp   = AXI_RESP_OKAY;
    end

    // register view for the translator
    always_comb begin
        cfg_o.plv  = crmd_q[1:0];
        cfg_o.da   = crmd_q[3];
        cfg_o.datf = crmd_q[6:5];
        cfg_o.datm = crmd_q[8:7];
        cfg_o.asid = asid_q[9:0];
        cfg_o.dmw0 = to_dmw(dmw0_q);
        cfg_o.dmw1 = to_dmw(dmw1_q);
    end

    // staged entry with its key asid from the asid register
    always_comb begin
        tlb_entry_o.key.e         = tlbehi_q[0];
        tlb_entry_o.key.g         = tlbehi_q[1];
        tlb_entry_o.key.huge_page = tlbehi_q[2];
        tlb_entry_o.key.vppn      = tlbehi_q[31:13];
        tlb_entry_o.key.asid      = asid_q[9:0];
        tlb_entry_o.even          = to_value(tlbelo0_q);
        tlb_entry_o.odd           = to_value(tlbelo1_q);
    end

    assign tlb_we_o = tlb_we_q;

endmodule

// File: logic/mmu_pkg.sv
package mmu_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [9:0]  asid_t;
    typedef logic [18:0] vppn_t;
    typedef logic [19:0] ppn_t;
    typedef logic [1:0]  mat_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;

    // configuration bus
    typedef logic [7:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef enum logic [1:0] {
        MEM_FETCH = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_kind_e;

    localparam ecode_t ECODE_NONE = 6'h00;
    localparam ecode_t ECODE_PIL  = 6'h01;
    localparam ecode_t ECODE_PIS  = 6'h02;
    localparam ecode_t ECODE_PIF  = 6'h03;
    localparam ecode_t ECODE_PME  = 6'h04;
    localparam ecode_t ECODE_PPI  = 6'h07;
    localparam ecode_t ECODE_TLBR = 6'h3f;

    typedef struct packed {
        logic  e;
        logic  g;
        asid_t asid;
        vppn_t vppn;
        logic  huge_page;
    } tlb_key_t;

    typedef struct packed {
        logic v;
        logic d;
        plv_t plv;
        mat_t mat;
        ppn_t ppn;
    } tlb_value_t;

    // one key covers an even/odd page pair
    typedef struct packed {
        tlb_key_t   key;
        tlb_value_t even;
        tlb_value_t odd;
    } tlb_entry_t;

    // direct-mapped window, decoded from the dmw register
    typedef struct packed {
        logic [2:0] vseg;
        logic [2:0] pseg;
        mat_t       mat;
        logic       plv3;
        logic       plv0;
    } dmw_t;

    typedef struct packed {
        plv_t  plv;
        logic  da;
        mat_t  datf;
        mat_t  datm;
        asid_t asid;
        dmw_t  dmw0;
        dmw_t  dmw1;
    } mmu_cfg_t;

    typedef struct packed {
        logic      valid;
        vaddr_t    va;
        mem_kind_e kind;
    } trans_req_t;

    typedef struct packed {
        logic   valid;
        logic   ok;
        paddr_t pa;
        mat_t   mat;
        ecode_t ecode;
    } trans_result_t;

    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        logic [1:0] rresp;
    } axil_rsp_t;

endpackage
